/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_qubit_dsp
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf $(BUILD_DIR)

/* acq_capture.sv */
// Saturating write address, write enable and delayed ADC data for one buffer

module acq_capture #(
	parameter int ACQ_ADDR_WIDTH = 6
) (
	input  logic                      dspif,
	input  logic                      arst_n,
	input  dsp_pkg::adc_sample_t      adc,
	input  logic                      acq_clear,
	output logic [ACQ_ADDR_WIDTH-1:0] acq_addr,
	output dsp_pkg::adc_sample_t      acq_data,
	output logic                      acq_we
);

	dsp_pkg::adc_sample_t adc_q;
	logic                 addr_full;

	// The buffer stops recording once its last location is written
	assign addr_full = &acq_addr;
	assign acq_we    = ~addr_full;

	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			adc_q    <= '0;
			acq_data <= '0;
			acq_addr <= '0;
		end else begin
			adc_q    <= adc;
			acq_data <= adc_q; // Two stages keep data in step with address
			if (acq_clear)
				acq_addr <= '0;
			else if (!addr_full)
				acq_addr <= acq_addr + 1'b1;
		end
	end

endmodule

/* cmd_fetch.sv */
// Command pointer, one-cycle read tracking and end-of-program detection

module cmd_fetch (
	input  logic                               dspif,
	input  logic                               arst_n,
	input  logic                               core_reset,
	output logic [cmd_pkg::CMD_ADDR_WIDTH-1:0] cmd_addr,
	input  cmd_pkg::cmd_word_t                 cmd_data,
	output cmd_pkg::cmd_word_t                 cmd,
	output logic                               cmd_valid,
	output logic                               done
);

	logic rd_issued; // cmd_data answers the address of the previous cycle
	logic end_word;

	// An all-zero word terminates the program
	assign end_word  = rd_issued && cmd_data == '0;
	assign cmd       = cmd_data;
	assign cmd_valid = rd_issued && !end_word;

	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			cmd_addr  <= '0;
			rd_issued <= 1'b0;
			done      <= 1'b0;
		end else if (core_reset) begin
			cmd_addr  <= '0;
			rd_issued <= 1'b0;
			done      <= 1'b0;
		end else begin
			rd_issued <= !done && !end_word;
			if (end_word)
				done <= 1'b1; // Held until the next core reset
			if (!done && !end_word)
				cmd_addr <= cmd_addr + 1'b1;
		end
	end

endmodule

/* cmd_pkg.sv */
// Command word layout, envelope views, element command and element select codes

package cmd_pkg;

	localparam int CMD_WIDTH      = 128;
	localparam int CMD_ADDR_WIDTH = 16;

	localparam int AMP_WIDTH   = 16;
	localparam int FREQ_WIDTH  = 9;
	localparam int PHASE_WIDTH = 17;
	localparam int ENV_WIDTH   = 12; // Envelope start and length as seen by an element

	typedef enum logic [1:0] {
		SEL_QDRV = 2'd0,
		SEL_RDRV = 2'd1,
		SEL_RDLO = 2'd2,
		SEL_NONE = 2'd3
	} elem_sel_t;

	// ==============================
	// Envelope word, two readings
	// ==============================

	// Qubit drive envelopes are shorter and leave a gap above each field
	typedef struct packed {
		logic [1:0] unused_hi;
		logic [9:0] length;
		logic [1:0] unused_lo;
		logic [9:0] start;
	} qdrv_env_t;

	typedef struct packed {
		logic [11:0] length;
		logic [11:0] start;
	} readout_env_t;

	typedef union packed {
		qdrv_env_t    qdrv;
		readout_env_t readout;
	} env_word_u;

	typedef struct packed {
		logic [CMD_WIDTH-71:0]  reserved; // Upper 58 bits carry nothing here
		logic [1:0]             mode;
		elem_sel_t              sel;
		env_word_u              env;
		logic [AMP_WIDTH-1:0]   amp;
		logic [FREQ_WIDTH-1:0]  freq;
		logic [PHASE_WIDTH-1:0] phase;
	} cmd_word_t;

	typedef struct packed {
		logic                   stb;
		logic [ENV_WIDTH-1:0]   env_start;
		logic [ENV_WIDTH-1:0]   env_length;
		logic [AMP_WIDTH-1:0]   amp;
		logic [FREQ_WIDTH-1:0]  freq;
		logic [PHASE_WIDTH-1:0] phase;
		logic [1:0]             mode;
	} elem_cmd_t;

endpackage

/* dsp_pkg.sv */
// Sample and shot-count widths plus ADC sample type for sequencing and capture

package dsp_pkg;

	// ==============================
	// Acquisition
	// ==============================

	localparam int ADC_WIDTH = 16;
	localparam int NUM_ACQ   = 2; // One capture channel per ADC stream

	// Two's complement ADC sample as delivered by the converter
	typedef logic signed [ADC_WIDTH-1:0] adc_sample_t;

	// ==============================
	// Shot sequencing
	// ==============================

	// Width of both the requested shot count and the running counter
	localparam int SHOT_WIDTH = 32;

endpackage

/* element_dispatch.sv */
// Command decode and registered strobe with fields for qdrv, rdrv and rdlo

module element_dispatch (
	input  logic               dspif,
	input  logic               arst_n,
	input  cmd_pkg::cmd_word_t cmd,
	input  logic               cmd_valid,
	output cmd_pkg::elem_cmd_t qdrv,
	output cmd_pkg::elem_cmd_t rdrv,
	output cmd_pkg::elem_cmd_t rdlo
);

	cmd_pkg::elem_cmd_t elem_q [3]; // Indexed by element select code
	logic [2:0]         hit;

	// Build the element command, reading the envelope through the matching view
	function automatic cmd_pkg::elem_cmd_t decode(input cmd_pkg::cmd_word_t w,
			input logic readout);
		cmd_pkg::elem_cmd_t e;
		e.stb = 1'b1;
		if (readout) begin
			e.env_start  = w.env.readout.start;
			e.env_length = w.env.readout.length;
		end else begin
			e.env_start  = {2'b00, w.env.qdrv.start};
			e.env_length = {2'b00, w.env.qdrv.length};
		end
		e.amp   = w.amp;
		e.freq  = w.freq;
		e.phase = w.phase;
		e.mode  = w.mode;
		return e;
	endfunction

	assign hit[0] = cmd_valid && cmd.sel == cmd_pkg::SEL_QDRV;
	assign hit[1] = cmd_valid && cmd.sel == cmd_pkg::SEL_RDRV;
	assign hit[2] = cmd_valid && cmd.sel == cmd_pkg::SEL_RDLO;

	// ==============================
	// Element registers
	// ==============================

	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 3; i++)
				elem_q[i] <= '0;
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (hit[i])
					elem_q[i] <= decode(cmd, i != 0);
				else
					elem_q[i].stb <= 1'b0; // Fields keep the last command
			end
		end
	end

	assign qdrv = elem_q[0];
	assign rdrv = elem_q[1];
	assign rdlo = elem_q[2];

endmodule

/* qubit_dsp.sv */
// DSP top level with shot sequencer, per-core fetch and dispatch, and ADC capture

module qubit_dsp #(
	parameter int NPROC          = 4,
	parameter int ACQ_ADDR_WIDTH = 6
) (
	input  logic                               dspif,
	input  logic                               arst_n,
	input  logic                               stb_start,
	input  logic [dsp_pkg::SHOT_WIDTH-1:0]     nshot,
	output logic [dsp_pkg::SHOT_WIDTH-1:0]     shot_cnt,
	output logic                               shot_busy,
	output logic                               last_shot_done,
	output logic [cmd_pkg::CMD_ADDR_WIDTH-1:0] cmd_addr [NPROC],
	input  cmd_pkg::cmd_word_t                 cmd_data [NPROC],
	output cmd_pkg::elem_cmd_t                 qdrv_cmd [NPROC],
	output cmd_pkg::elem_cmd_t                 rdrv_cmd [NPROC],
	output cmd_pkg::elem_cmd_t                 rdlo_cmd [NPROC],
	input  dsp_pkg::adc_sample_t               adc [dsp_pkg::NUM_ACQ],
	input  logic                               acq_clear,
	output logic [ACQ_ADDR_WIDTH-1:0]          acq_addr [dsp_pkg::NUM_ACQ],
	output dsp_pkg::adc_sample_t               acq_data [dsp_pkg::NUM_ACQ],
	output logic [dsp_pkg::NUM_ACQ-1:0]        acq_we
);

	logic [NPROC-1:0] core_reset;
	logic [NPROC-1:0] core_done;

	// ==============================
	// Shot sequencing
	// ==============================

	shot_sequencer #(
		.NPROC(NPROC)
	) u_sequencer (
		.dspif(dspif),
		.arst_n(arst_n),
		.stb_start(stb_start),
		.nshot(nshot),
		.core_done(core_done),
		.core_reset(core_reset),
		.shot_cnt(shot_cnt),
		.shot_busy(shot_busy),
		.last_shot_done(last_shot_done)
	);

	// ==============================
	// Command cores
	// ==============================

	for (genvar i = 0; i < NPROC; i++) begin : g_core
		cmd_pkg::cmd_word_t cmd;
		logic               cmd_valid;

		cmd_fetch u_fetch (
			.dspif(dspif),
			.arst_n(arst_n),
			.core_reset(core_reset[i]),
			.cmd_addr(cmd_addr[i]),
			.cmd_data(cmd_data[i]),
			.cmd(cmd),
			.cmd_valid(cmd_valid),
			.done(core_done[i])
		);

		element_dispatch u_dispatch (
			.dspif(dspif),
			.arst_n(arst_n),
			.cmd(cmd),
			.cmd_valid(cmd_valid),
			.qdrv(qdrv_cmd[i]),
			.rdrv(rdrv_cmd[i]),
			.rdlo(rdlo_cmd[i])
		);
	end

	// ==============================
	// Acquisition
	// ==============================

	// Both buffers restart together on acq_clear
	for (genvar j = 0; j < dsp_pkg::NUM_ACQ; j++) begin : g_acq
		acq_capture #(
			.ACQ_ADDR_WIDTH(ACQ_ADDR_WIDTH)
		) u_capture (
			.dspif(dspif),
			.arst_n(arst_n),
			.adc(adc[j]),
			.acq_clear(acq_clear),
			.acq_addr(acq_addr[j]),
			.acq_data(acq_data[j]),
			.acq_we(acq_we[j])
		);
	end

endmodule

/* shot_sequencer.sv */
// Multi-shot run state machine with shot counter and two-cycle core reset

module shot_sequencer #(
	parameter int NPROC = 4
) (
	input  logic                           dspif,
	input  logic                           arst_n,
	input  logic                           stb_start,
	input  logic [dsp_pkg::SHOT_WIDTH-1:0] nshot,
	input  logic [NPROC-1:0]               core_done,
	output logic [NPROC-1:0]               core_reset,
	output logic [dsp_pkg::SHOT_WIDTH-1:0] shot_cnt,
	output logic                           shot_busy,
	output logic                           last_shot_done
);

	localparam logic [1:0] ST_IDLE  = 2'd0;
	localparam logic [1:0] ST_RESET = 2'd1;
	localparam logic [1:0] ST_RUN   = 2'd2;
	localparam logic [1:0] ST_REARM = 2'd3;

	logic [1:0]                     state;
	logic                           phase; // Marks the second cycle of RESET and REARM
	logic                           start_q;
	logic                           all_done_q;
	logic [dsp_pkg::SHOT_WIDTH-1:0] nshot_q;
	logic                           all_done;
	logic                           shot_end;
	logic                           last_shot;

	assign all_done  = &core_done;
	assign shot_end  = all_done & ~all_done_q;
	assign last_shot = shot_cnt == nshot_q - 1'b1;

	// Cores stay parked in reset whenever no shot is in flight
	assign core_reset = {NPROC{state == ST_IDLE || state == ST_RESET}};

	// ==============================
	// Sequencing
	// ==============================

	always_ff @(posedge dspif or negedge arst_n) begin
		if (!arst_n) begin
			state          <= ST_IDLE;
			phase          <= 1'b0;
			start_q        <= 1'b0;
			all_done_q     <= 1'b0;
			nshot_q        <= '0;
			shot_cnt       <= '0;
			shot_busy      <= 1'b0;
			last_shot_done <= 1'b0;
		end else begin
			start_q        <= stb_start;
			all_done_q     <= all_done;
			last_shot_done <= 1'b0;
			phase          <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start_q) begin
						nshot_q   <= nshot;
						shot_cnt  <= '0;
						shot_busy <= 1'b1;
						state     <= ST_RESET;
					end
				end
				ST_RESET: begin
					phase <= ~phase;
					if (phase)
						state <= ST_RUN;
				end
				ST_RUN: begin
					if (shot_end && last_shot) begin
						last_shot_done <= 1'b1;
						shot_busy      <= 1'b0;
						state          <= ST_IDLE;
					end else if (shot_end) begin
						shot_cnt <= shot_cnt + 1'b1;
						state    <= ST_REARM; // Two idle cycles before the next reset
					end
				end
				ST_REARM: begin
					phase <= ~phase;
					if (phase)
						state <= ST_RESET;
				end
			endcase
		end
	end

endmodule

/* tb_qubit_dsp.sv */
// Testbench for qubit_dsp with command memory model, strobe reference model and capture checks

module tb_qubit_dsp;

	localparam int NPROC          = 4;
	localparam int ACQ_ADDR_WIDTH = 6;
	localparam int NUM_ACQ        = dsp_pkg::NUM_ACQ;
	localparam int PROG_DEPTH     = 8;

	logic                               dspif = 1'b0;
	logic                               arst_n = 1'b0;
	logic                               stb_start = 1'b0;
	logic [dsp_pkg::SHOT_WIDTH-1:0]     nshot = '0;
	logic [dsp_pkg::SHOT_WIDTH-1:0]     shot_cnt;
	logic                               shot_busy;
	logic                               last_shot_done;
	logic [cmd_pkg::CMD_ADDR_WIDTH-1:0] cmd_addr [NPROC];
	cmd_pkg::cmd_word_t                 cmd_data [NPROC] = '{default: '0};
	cmd_pkg::elem_cmd_t                 qdrv_cmd [NPROC];
	cmd_pkg::elem_cmd_t                 rdrv_cmd [NPROC];
	cmd_pkg::elem_cmd_t                 rdlo_cmd [NPROC];
	dsp_pkg::adc_sample_t               adc [NUM_ACQ] = '{default: '0};
	logic                               acq_clear = 1'b0;
	logic [ACQ_ADDR_WIDTH-1:0]          acq_addr [NUM_ACQ];
	dsp_pkg::adc_sample_t               acq_data [NUM_ACQ];
	logic [NUM_ACQ-1:0]                 acq_we;

	logic [127:0]              prog [NPROC][PROG_DEPTH] = '{default: '0};
	logic [127:0]              exp_word [NPROC][PROG_DEPTH] = '{default: '0};
	int                        exp_len [NPROC] = '{default: 0};
	int                        obs_cnt [NPROC] = '{default: 0};
	int                        obs_base [NPROC] = '{default: 0};
	int                        run_nshot = 0;
	int                        ldone_cnt = 0;
	int                        ldone_base = 0;
	int                        err_cnt = 0;
	int                        tests_passed = 0;
	int                        tests_failed = 0;
	logic [ACQ_ADDR_WIDTH-1:0] exp_addr = '0;
	dsp_pkg::adc_sample_t      adc_d1 [NUM_ACQ] = '{default: '0};
	dsp_pkg::adc_sample_t      adc_d2 [NUM_ACQ] = '{default: '0};

	qubit_dsp #(
		.NPROC(NPROC),
		.ACQ_ADDR_WIDTH(ACQ_ADDR_WIDTH)
	) DUT (
		.dspif(dspif),
		.arst_n(arst_n),
		.stb_start(stb_start),
		.nshot(nshot),
		.shot_cnt(shot_cnt),
		.shot_busy(shot_busy),
		.last_shot_done(last_shot_done),
		.cmd_addr(cmd_addr),
		.cmd_data(cmd_data),
		.qdrv_cmd(qdrv_cmd),
		.rdrv_cmd(rdrv_cmd),
		.rdlo_cmd(rdlo_cmd),
		.adc(adc),
		.acq_clear(acq_clear),
		.acq_addr(acq_addr),
		.acq_data(acq_data),
		.acq_we(acq_we)
	);

	always #5 dspif = ~dspif;

	task automatic compare_values(input string what, input logic [127:0] got,
			input logic [127:0] exp);
		if (got !== exp) begin
			$display("ERROR @%0t: %s: got %0h, expected %0h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic abort_run(input string reason);
		$display("Timeout: %s", reason);
		$display("Verification failed");
		$finish;
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (err_cnt == errs_before) begin
			tests_passed++;
			$display("Test %s: ok", name);
		end else begin
			tests_failed++;
			$display("Test %s: %0d mismatches", name, err_cnt - errs_before);
		end
	endtask

	// Element command built straight from the bit layout of the command word
	function automatic logic [68:0] expect_elem(input logic [127:0] w);
		logic [11:0] start;
		logic [11:0] length;
		if (w[67:66] == 2'd0) begin
			start  = {2'b00, w[51:42]};
			length = {2'b00, w[63:54]}; // Short qdrv fields sit above a 2-bit gap
		end else begin
			start  = w[53:42];
			length = w[65:54];
		end
		return {1'b1, start, length, w[41:26], w[25:17], w[16:0], w[69:68]};
	endfunction

	task automatic new_programs();
		logic [127:0] word;
		int           len;
		for (int i = 0; i < NPROC; i++) begin
			len        = 1 + $urandom % 6;
			exp_len[i] = 0;
			for (int w = 0; w < PROG_DEPTH; w++)
				prog[i][w] = '0; // The word after the last one ends the program
			for (int w = 0; w < len; w++) begin
				word          = {$urandom, $urandom, $urandom, $urandom};
				word[67:66]   = 2'($urandom);
				if (word == '0)
					word[127] = 1'b1;
				prog[i][w] = word;
				if (word[67:66] != 2'd3) begin
					exp_word[i][exp_len[i]] = word;
					exp_len[i]++;
				end
			end
		end
	endtask

	// ==============================
	// Memory, ADC and models
	// ==============================

	always @(posedge dspif) begin : stimulus
		logic [31:0] r;
		for (int i = 0; i < NPROC; i++) begin
			if (cmd_addr[i] < 16'(PROG_DEPTH))
				cmd_data[i] <= prog[i][cmd_addr[i][2:0]];
			else
				cmd_data[i] <= '0;
		end
		for (int j = 0; j < NUM_ACQ; j++) begin
			r = $urandom;
			adc[j] <= r[15:0];
		end
	end

	always @(posedge dspif) begin : acq_model
		if (!arst_n) begin
			exp_addr <= '0;
			for (int j = 0; j < NUM_ACQ; j++) begin
				adc_d1[j] <= '0;
				adc_d2[j] <= '0;
			end
		end else begin
			if (acq_clear)
				exp_addr <= '0;
			else if (exp_addr != '1)
				exp_addr <= exp_addr + 1'b1; // Locks at the last location
			for (int j = 0; j < NUM_ACQ; j++) begin
				adc_d1[j] <= adc[j];
				adc_d2[j] <= adc_d1[j];
			end
		end
	end

	always @(negedge dspif) begin : monitor
		logic [2:0]  stbs;
		logic [68:0] got;
		int          n;
		int          k;
		if (arst_n) begin
			if (last_shot_done)
				ldone_cnt++;
			for (int i = 0; i < NPROC; i++) begin
				stbs = {rdlo_cmd[i].stb, rdrv_cmd[i].stb, qdrv_cmd[i].stb};
				for (int e = 0; e < 3; e++) begin
					if (stbs[e]) begin
						case (e)
							0: got = qdrv_cmd[i];
							1: got = rdrv_cmd[i];
							default: got = rdlo_cmd[i];
						endcase
						n = obs_cnt[i] - obs_base[i];
						compare_values($sformatf("core %0d strobe within program", i),
							128'(n < exp_len[i] * run_nshot), 128'(1));
						if (n < exp_len[i] * run_nshot) begin
							k = n % exp_len[i]; // Same list again on every shot
							compare_values($sformatf("core %0d element", i), 128'(e),
								128'(exp_word[i][k][67:66]));
							compare_values($sformatf("core %0d fields", i), 128'(got),
								128'(expect_elem(exp_word[i][k])));
						end
						obs_cnt[i]++;
					end
				end
			end
			for (int j = 0; j < NUM_ACQ; j++) begin
				compare_values($sformatf("acq_addr %0d", j), 128'(acq_addr[j]), 128'(exp_addr));
				compare_values($sformatf("acq_we %0d", j), 128'(acq_we[j]),
					128'(exp_addr != '1));
				compare_values($sformatf("acq_data %0d", j), 128'(acq_data[j]),
					128'(adc_d2[j]));
			end
		end
	end

	// ==============================
	// Tests
	// ==============================

	task automatic run_shots(input string name);
		logic [dsp_pkg::SHOT_WIDTH-1:0] shots;
		int                             errs;
		int                             cycles;
		errs = err_cnt;
		new_programs();
		shots     = 1 + ($urandom % 4);
		run_nshot = shots;
		for (int i = 0; i < NPROC; i++)
			obs_base[i] = obs_cnt[i];
		ldone_base = ldone_cnt;
		@(posedge dspif);
		nshot     <= shots;
		stb_start <= 1'b1;
		@(posedge dspif);
		stb_start <= 1'b0;
		repeat (2) @(negedge dspif); // Start is registered, then the count is latched
		compare_values("shot_busy after start", 128'(shot_busy), 128'(1));
		compare_values("shot_cnt after start", 128'(shot_cnt), 128'(0));
		cycles = 0;
		while (ldone_cnt == ldone_base) begin
			@(posedge dspif);
			cycles++;
			if (cycles > 2000)
				abort_run("last_shot_done did not pulse within 2000 cycles");
		end
		repeat (5) @(negedge dspif);
		compare_values("last_shot_done pulses", 128'(ldone_cnt - ldone_base), 128'(1));
		compare_values("shot_busy after run", 128'(shot_busy), 128'(0));
		compare_values("shot_cnt after run", 128'(shot_cnt), 128'(shots - 1));
		for (int i = 0; i < NPROC; i++)
			compare_values($sformatf("core %0d strobe total", i),
				128'(obs_cnt[i] - obs_base[i]), 128'(exp_len[i] * run_nshot));
		report_test(name, errs);
	endtask

	task automatic wait_acq_full(input string what);
		int cycles;
		cycles = 0;
		while (acq_addr[0] != '1) begin
			@(negedge dspif);
			cycles++;
			if (cycles > 200)
				abort_run(what);
		end
	endtask

	task automatic capture_test();
		int errs;
		int cycles;
		errs = err_cnt;
		wait_acq_full("acquisition address did not reach its last location");
		repeat (3) begin
			@(negedge dspif);
			for (int j = 0; j < NUM_ACQ; j++) begin
				compare_values("held acq_addr", 128'(acq_addr[j]), 128'({ACQ_ADDR_WIDTH{1'b1}}));
				compare_values("acq_we when full", 128'(acq_we[j]), 128'(0));
			end
		end
		@(posedge dspif);
		acq_clear <= 1'b1;
		@(posedge dspif);
		acq_clear <= 1'b0;
		@(negedge dspif);
		for (int j = 0; j < NUM_ACQ; j++) begin
			compare_values("acq_addr after clear", 128'(acq_addr[j]), 128'(0));
			compare_values("acq_we after clear", 128'(acq_we[j]), 128'(1));
		end
		cycles = 0;
		while (acq_addr[0] != '1) begin
			@(negedge dspif);
			cycles++;
			if (cycles > 200)
				abort_run("acquisition address did not refill after clear");
		end
		compare_values("cycles from clear to full", 128'(cycles), 128'(2 ** ACQ_ADDR_WIDTH - 1));
		report_test("capture", errs);
	endtask

	initial begin : main
		int errs;
		void'($urandom(32'h1932_da54));
		errs = err_cnt;
		repeat (2) @(posedge dspif);
		@(negedge dspif);
		for (int i = 0; i < NPROC; i++)
			compare_values($sformatf("core %0d strobes in reset", i),
				128'({qdrv_cmd[i].stb, rdrv_cmd[i].stb, rdlo_cmd[i].stb}), 128'(0));
		compare_values("shot_busy in reset", 128'(shot_busy), 128'(0));
		compare_values("last_shot_done in reset", 128'(last_shot_done), 128'(0));
		for (int j = 0; j < NUM_ACQ; j++)
			compare_values("acq_addr in reset", 128'(acq_addr[j]), 128'(0));
		@(posedge dspif);
		arst_n <= 1'b1;
		@(negedge dspif);
		for (int j = 0; j < NUM_ACQ; j++)
			compare_values("acq_addr after reset", 128'(acq_addr[j]), 128'(0));
		report_test("reset", errs);
		run_shots("first run");
		run_shots("second run");
		capture_test();
		$display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
			err_cnt);
		if (tests_failed == 0 && err_cnt == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* verilog.f */
dsp_pkg.sv
cmd_pkg.sv
shot_sequencer.sv
cmd_fetch.sv
element_dispatch.sv
acq_capture.sv
qubit_dsp.sv
tb_qubit_dsp.sv
